// ==== mini_pipe_defs.svh ====
//////////////////////////////////////////////////////////////////////
// Widths, instruction field map and the load data rule
// The field positions assume a 16-bit instruction with 3-bit opcode
//////////////////////////////////////////////////////////////////////

`ifndef MINI_PIPE_DEFS_SVH
`define MINI_PIPE_DEFS_SVH

// Datapath and register file widths
`define MP_XLEN          16
`define MP_RADDR_W       3
`define MP_INSTR_W       16
`define MP_OPC_W         3
`define MP_IMM_W         4

// Instruction field positions
`define MP_F_OPC         15:13
`define MP_F_RD          12:10
`define MP_F_RS1         9:7
`define MP_F_RS2         6:4
`define MP_F_IMM         3:0

// A load returns its address XOR this value
`define MP_LOAD_PATTERN  16'hA5C3

`endif

// ==== mini_pipe_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Opcode and forwarding select types shared across the pipeline
// Codes 6 and 7 have no name here and are turned into NOP in ID
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "mini_pipe_defs.svh"

package mini_pipe_pkg;

  // Opcodes as carried from ID into EX
  typedef enum logic [`MP_OPC_W-1:0] {
    OP_NOP  = 3'd0,
    OP_ADD  = 3'd1,
    OP_SUB  = 3'd2,
    OP_XOR  = 3'd3,
    OP_ADDI = 3'd4,
    OP_LD   = 3'd5
  } opcode_e;

  // Operand source in ID
  typedef enum logic [1:0] {
    SEL_REGFILE = 2'b00,
    SEL_FW_EX   = 2'b01,
    SEL_FW_WB   = 2'b10
  } fw_sel_e;

endpackage

`default_nettype wire

// ==== mini_pipe_decoder.sv ====
//////////////////////////////////////////////////////////////////////
// ID stage with the IF/ID register and field decode
// Source must hold instr_i while stall_i is high
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "mini_pipe_defs.svh"

module mini_pipe_decoder import mini_pipe_pkg::*; (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   instr_valid_i,
  input  logic [`MP_INSTR_W-1:0] instr_i,
  input  logic                   stall_i,
  output logic                   id_valid_o,
  output opcode_e                opcode_o,
  output logic [`MP_RADDR_W-1:0] rd_o,
  output logic [`MP_RADDR_W-1:0] rf_raddr_a_o,
  output logic [`MP_RADDR_W-1:0] rf_raddr_b_o,
  output logic [`MP_IMM_W-1:0]   imm_o,
  output logic [1:0]             rf_re_o,
  output logic                   id_we_o
);

  logic [`MP_INSTR_W-1:0] instr_q;
  logic [`MP_OPC_W-1:0]   opc_raw;

  // Valid follows the strobe whenever ID is free to move
  // Without a new strobe the slot empties as the old one leaves
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      id_valid_o <= 1'b0;
    end else if (!stall_i) begin
      id_valid_o <= instr_valid_i;
    end
  end

  // Instruction word, loaded on acceptance only
  always_ff @(posedge clk_i) begin
    if (instr_valid_i && !stall_i) begin
      instr_q <= instr_i;
    end
  end

  // Field split
  assign opc_raw      = instr_q[`MP_F_OPC];
  assign rd_o         = instr_q[`MP_F_RD];
  assign rf_raddr_a_o = instr_q[`MP_F_RS1];
  assign rf_raddr_b_o = instr_q[`MP_F_RS2];
  assign imm_o        = instr_q[`MP_F_IMM];

  // Undefined codes fall back to NOP
  always_comb begin
    case (opc_raw)
      OP_ADD, OP_SUB, OP_XOR, OP_ADDI, OP_LD: opcode_o = opcode_e'(opc_raw);
      default:                                opcode_o = OP_NOP;
    endcase
  end

  // Port a for every real opcode, port b for register-register ops
  assign rf_re_o[0] = (opcode_o != OP_NOP);
  assign rf_re_o[1] = (opcode_o == OP_ADD) || (opcode_o == OP_SUB) || (opcode_o == OP_XOR);

  // No write for NOP or a destination of r0
  assign id_we_o = (opcode_o != OP_NOP) && (rd_o != '0);

endmodule

`default_nettype wire

// ==== mini_pipe_regfile.sv ====
//////////////////////////////////////////////////////////////////////
// Eight-entry register file with r0 tied to zero
// Reads are asynchronous and miss a write on the same edge
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "mini_pipe_defs.svh"

module mini_pipe_regfile (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic [`MP_RADDR_W-1:0] raddr_a_i,
  input  logic [`MP_RADDR_W-1:0] raddr_b_i,
  input  logic                   we_i,
  input  logic [`MP_RADDR_W-1:0] waddr_i,
  input  logic [`MP_XLEN-1:0]    wdata_i,
  output logic [`MP_XLEN-1:0]    rdata_a_o,
  output logic [`MP_XLEN-1:0]    rdata_b_o
);

  localparam int NREGS = 2 ** `MP_RADDR_W;

  // Storage for r1 upward
  logic [`MP_XLEN-1:0] regs_q [1:NREGS-1];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 1; i < NREGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // r0 reads as zero
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

`default_nettype wire

// ==== mini_pipe_bypass.sv ====
//////////////////////////////////////////////////////////////////////
// Hazard detection, load-use stall and operand forwarding selects
// Purely combinational; the clock only samples the assertions
// Register 0 never matches and EX wins over WB on a double match
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "mini_pipe_defs.svh"

module mini_pipe_bypass import mini_pipe_pkg::*; (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic [1:0]             rf_re_i,
  input  logic [`MP_RADDR_W-1:0] rf_raddr_a_i,
  input  logic [`MP_RADDR_W-1:0] rf_raddr_b_i,
  input  logic                   id_valid_i,
  input  logic                   ex_valid_i,
  input  logic                   ex_we_i,
  input  logic [`MP_RADDR_W-1:0] ex_waddr_i,
  input  logic                   ex_is_load_i,
  input  logic                   wb_valid_i,
  input  logic                   wb_we_i,
  input  logic [`MP_RADDR_W-1:0] wb_waddr_i,
  input  logic                   wb_ready_i,
  output fw_sel_e                fw_sel_a_o,
  output fw_sel_e                fw_sel_b_o,
  output logic                   stall_o
);

  logic [`MP_RADDR_W-1:0] raddr [2];
  logic [1:0]             ex_match;
  logic [1:0]             wb_match;
  logic                   rf_we_ex;
  logic                   rf_we_wb;
  logic                   load_stall;

  //////////////////////////////////////////////////////////////////////
  // Address compare
  //////////////////////////////////////////////////////////////////////

  assign raddr[0] = rf_raddr_a_i;
  assign raddr[1] = rf_raddr_b_i;

  // Writers in flight
  assign rf_we_ex = ex_valid_i && ex_we_i;
  // WB write only counts once the data is final
  assign rf_we_wb = wb_valid_i && wb_we_i;

  // Per read port, qualified by a live ID read of a nonzero register
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      ex_match[i] = rf_we_ex && id_valid_i && rf_re_i[i] && (raddr[i] != '0) &&
                    (raddr[i] == ex_waddr_i);
      wb_match[i] = rf_we_wb && id_valid_i && rf_re_i[i] && (raddr[i] != '0) &&
                    (raddr[i] == wb_waddr_i);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stall and forwarding selects
  //////////////////////////////////////////////////////////////////////

  // Load result is not there until WB
  assign load_stall = ex_is_load_i && |ex_match;
  // WB wait state holds the whole pipe
  assign stall_o    = load_stall || !wb_ready_i;

  // EX select overrides WB since it is the younger write
  always_comb begin
    fw_sel_a_o = SEL_REGFILE;
    fw_sel_b_o = SEL_REGFILE;
    if (wb_match[0]) begin
      fw_sel_a_o = SEL_FW_WB;
    end
    if (wb_match[1]) begin
      fw_sel_b_o = SEL_FW_WB;
    end
    if (ex_match[0]) begin
      fw_sel_a_o = SEL_FW_EX;
    end
    if (ex_match[1]) begin
      fw_sel_b_o = SEL_FW_EX;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////////////////////////

  // A load hit in EX leaves a bubble there on the next ready edge
  // The load address is never taken as an operand
  a_no_load_fw_ex: assert property (@(posedge clk_i) disable iff (reset_i)
    (load_stall && wb_ready_i) |=> !load_stall);

  // Pipe comes out of reset empty and ready
  a_no_stall_after_reset: assert property (@(posedge clk_i)
    $past(reset_i) && !reset_i |-> !stall_o);

endmodule

`default_nettype wire

// ==== mini_pipe_ex.sv ====
//////////////////////////////////////////////////////////////////////
// EX stage with forwarding muxes, ID/EX register and ALU
// ex_result_o carries the address for a load
// Holds while WB is not ready and takes a bubble on other stalls
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "mini_pipe_defs.svh"

module mini_pipe_ex import mini_pipe_pkg::*; (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   id_valid_i,
  input  opcode_e                opcode_i,
  input  logic [`MP_RADDR_W-1:0] rd_i,
  input  logic [`MP_IMM_W-1:0]   imm_i,
  input  logic                   id_we_i,
  input  logic [`MP_XLEN-1:0]    rdata_a_i,
  input  logic [`MP_XLEN-1:0]    rdata_b_i,
  input  fw_sel_e                fw_sel_a_i,
  input  fw_sel_e                fw_sel_b_i,
  input  logic                   stall_i,
  input  logic                   wb_ready_i,
  input  logic [`MP_XLEN-1:0]    wb_wdata_i,
  output logic                   ex_valid_o,
  output logic                   ex_we_o,
  output logic [`MP_RADDR_W-1:0] ex_waddr_o,
  output logic                   ex_is_load_o,
  output logic [`MP_XLEN-1:0]    ex_result_o
);

  opcode_e                opcode_q;
  logic [`MP_IMM_W-1:0]   imm_q;
  logic [`MP_XLEN-1:0]    op_a_q;
  logic [`MP_XLEN-1:0]    op_b_q;
  logic [`MP_XLEN-1:0]    op_a_d;
  logic [`MP_XLEN-1:0]    op_b_d;
  logic [`MP_XLEN-1:0]    imm_ext;

  // Operand source pick, same for both ports
  function automatic logic [`MP_XLEN-1:0] fw_mux(
    input fw_sel_e             sel,
    input logic [`MP_XLEN-1:0] rf_val,
    input logic [`MP_XLEN-1:0] ex_val,
    input logic [`MP_XLEN-1:0] wb_val
  );
    case (sel)
      SEL_FW_EX: return ex_val;
      SEL_FW_WB: return wb_val;
      default:   return rf_val;
    endcase
  endfunction

  assign op_a_d = fw_mux(fw_sel_a_i, rdata_a_i, ex_result_o, wb_wdata_i);
  assign op_b_d = fw_mux(fw_sel_b_i, rdata_b_i, ex_result_o, wb_wdata_i);

  //////////////////////////////////////////////////////////////////////
  // ID/EX register
  //////////////////////////////////////////////////////////////////////

  // Valid bit. WB wait freezes EX, a hazard stall injects a bubble
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ex_valid_o <= 1'b0;
    end else if (wb_ready_i) begin
      ex_valid_o <= id_valid_i && !stall_i;
    end
  end

  // Payload
  always_ff @(posedge clk_i) begin
    if (wb_ready_i && !stall_i) begin
      opcode_q   <= opcode_i;
      ex_waddr_o <= rd_i;
      ex_we_o    <= id_we_i;
      imm_q      <= imm_i;
      op_a_q     <= op_a_d;
      op_b_q     <= op_b_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // ALU and address adder
  //////////////////////////////////////////////////////////////////////

  // Immediate is zero-extended
  assign imm_ext = {{(`MP_XLEN - `MP_IMM_W){1'b0}}, imm_q};

  always_comb begin
    case (opcode_q)
      OP_ADD:        ex_result_o = op_a_q + op_b_q;
      OP_SUB:        ex_result_o = op_a_q - op_b_q;
      OP_XOR:        ex_result_o = op_a_q ^ op_b_q;
      OP_ADDI, OP_LD: ex_result_o = op_a_q + imm_ext;
      default:       ex_result_o = '0;
    endcase
  end

  assign ex_is_load_o = (opcode_q == OP_LD);

  // ID folds codes 6 and 7 into NOP before they reach here
  a_opcode_defined: assert property (@(posedge clk_i) disable iff (reset_i)
    ex_valid_o |-> (opcode_q <= OP_LD));

endmodule

`default_nettype wire

// ==== mini_pipe_wb.sv ====
//////////////////////////////////////////////////////////////////////
// WB stage with the EX/WB register, load data and wait-state hold
// mem_wait_i only holds the stage while it carries a load
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "mini_pipe_defs.svh"

module mini_pipe_wb (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   mem_wait_i,
  input  logic                   ex_valid_i,
  input  logic                   ex_we_i,
  input  logic [`MP_RADDR_W-1:0] ex_waddr_i,
  input  logic                   ex_is_load_i,
  input  logic [`MP_XLEN-1:0]    ex_result_i,
  output logic                   wb_ready_o,
  output logic                   wb_valid_o,
  output logic                   wb_we_o,
  output logic [`MP_RADDR_W-1:0] wb_waddr_o,
  output logic [`MP_XLEN-1:0]    wb_wdata_o
);

  logic                valid_q;
  logic                we_q;
  logic                is_load_q;
  logic [`MP_XLEN-1:0] result_q;

  // EX/WB register, refilled on every ready cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else if (wb_ready_o) begin
      valid_q <= ex_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wb_ready_o) begin
      we_q       <= ex_we_i;
      wb_waddr_o <= ex_waddr_i;
      is_load_q  <= ex_is_load_i;
      result_q   <= ex_result_i;
    end
  end

  // Only a held load can wait
  assign wb_ready_o = !(valid_q && is_load_q && mem_wait_i);

  // Pending write, then the retire pulse when the data is final
  assign wb_we_o    = valid_q && we_q;
  assign wb_valid_o = wb_we_o && wb_ready_o;

  // Load data rule
  assign wb_wdata_o = is_load_q ? (result_q ^ `MP_LOAD_PATTERN) : result_q;

  // A retired load leaves. A second pulse needs a new writer from EX
  a_single_load_retire: assert property (@(posedge clk_i) disable iff (reset_i)
    (wb_valid_o && is_load_q) |=> (!wb_valid_o || $past(ex_valid_i && ex_we_i)));

endmodule

`default_nettype wire

// ==== mini_pipe_top.sv ====
//////////////////////////////////////////////////////////////////////
// Three-stage ID, EX, WB pipeline slice
// Source holds its instruction while stall_o is high
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "mini_pipe_defs.svh"

module mini_pipe_top import mini_pipe_pkg::*; (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   instr_valid_i,
  input  logic [`MP_INSTR_W-1:0] instr_i,
  input  logic                   mem_wait_i,
  output logic                   stall_o,
  output logic                   wb_valid_o,
  output logic [`MP_RADDR_W-1:0] wb_waddr_o,
  output logic [`MP_XLEN-1:0]    wb_wdata_o
);

  // ID outputs
  logic                   id_valid;
  opcode_e                id_opcode;
  logic [`MP_RADDR_W-1:0] id_rd;
  logic [`MP_RADDR_W-1:0] rf_raddr_a;
  logic [`MP_RADDR_W-1:0] rf_raddr_b;
  logic [`MP_IMM_W-1:0]   id_imm;
  logic [1:0]             rf_re;
  logic                   id_we;
  logic [`MP_XLEN-1:0]    rdata_a;
  logic [`MP_XLEN-1:0]    rdata_b;

  // EX outputs
  logic                   ex_valid;
  logic                   ex_we;
  logic [`MP_RADDR_W-1:0] ex_waddr;
  logic                   ex_is_load;
  logic [`MP_XLEN-1:0]    ex_result;

  // WB and bypass
  logic                   wb_ready;
  logic                   wb_we;
  fw_sel_e                fw_sel_a;
  fw_sel_e                fw_sel_b;

  mini_pipe_decoder i_decoder (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .stall_i       (stall_o),
    .id_valid_o    (id_valid),
    .opcode_o      (id_opcode),
    .rd_o          (id_rd),
    .rf_raddr_a_o  (rf_raddr_a),
    .rf_raddr_b_o  (rf_raddr_b),
    .imm_o         (id_imm),
    .rf_re_o       (rf_re),
    .id_we_o       (id_we)
  );

  // Written on the retire pulse only
  mini_pipe_regfile i_regfile (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .raddr_a_i (rf_raddr_a),
    .raddr_b_i (rf_raddr_b),
    .we_i      (wb_valid_o),
    .waddr_i   (wb_waddr_o),
    .wdata_i   (wb_wdata_o),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b)
  );

  mini_pipe_bypass i_bypass (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .rf_re_i      (rf_re),
    .rf_raddr_a_i (rf_raddr_a),
    .rf_raddr_b_i (rf_raddr_b),
    .id_valid_i   (id_valid),
    .ex_valid_i   (ex_valid),
    .ex_we_i      (ex_we),
    .ex_waddr_i   (ex_waddr),
    .ex_is_load_i (ex_is_load),
    .wb_valid_i   (wb_valid_o),
    .wb_we_i      (wb_we),
    .wb_waddr_i   (wb_waddr_o),
    .wb_ready_i   (wb_ready),
    .fw_sel_a_o   (fw_sel_a),
    .fw_sel_b_o   (fw_sel_b),
    .stall_o      (stall_o)
  );

  mini_pipe_ex i_ex (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .id_valid_i   (id_valid),
    .opcode_i     (id_opcode),
    .rd_i         (id_rd),
    .imm_i        (id_imm),
    .id_we_i      (id_we),
    .rdata_a_i    (rdata_a),
    .rdata_b_i    (rdata_b),
    .fw_sel_a_i   (fw_sel_a),
    .fw_sel_b_i   (fw_sel_b),
    .stall_i      (stall_o),
    .wb_ready_i   (wb_ready),
    .wb_wdata_i   (wb_wdata_o),
    .ex_valid_o   (ex_valid),
    .ex_we_o      (ex_we),
    .ex_waddr_o   (ex_waddr),
    .ex_is_load_o (ex_is_load),
    .ex_result_o  (ex_result)
  );

  mini_pipe_wb i_wb (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .mem_wait_i   (mem_wait_i),
    .ex_valid_i   (ex_valid),
    .ex_we_i      (ex_we),
    .ex_waddr_i   (ex_waddr),
    .ex_is_load_i (ex_is_load),
    .ex_result_i  (ex_result),
    .wb_ready_o   (wb_ready),
    .wb_valid_o   (wb_valid_o),
    .wb_we_o      (wb_we),
    .wb_waddr_o   (wb_waddr_o),
    .wb_wdata_o   (wb_wdata_o)
  );

endmodule

`default_nettype wire

// ==== mini_pipe_tb.sv ====
//////////////////////////////////////////////////////////////////////
// Table-driven testbench for the mini_pipe top level
// Expected write-backs come from an in-order model of the table
// mem_wait_i is random only while the random part of the table runs
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module mini_pipe_tb;

  localparam int          N_RANDOM    = 200;
  localparam int          STALL_LIMIT = 64;
  localparam int          DRAIN_LIMIT = 400;
  localparam logic [15:0] LOAD_XOR    = 16'hA5C3;

  // Opcode field values
  localparam logic [2:0] NOP  = 3'd0;
  localparam logic [2:0] ADD  = 3'd1;
  localparam logic [2:0] SUB  = 3'd2;
  localparam logic [2:0] XOR  = 3'd3;
  localparam logic [2:0] ADDI = 3'd4;
  localparam logic [2:0] LD   = 3'd5;

  logic        clk;
  logic        reset;
  logic        instr_valid;
  logic [15:0] instr;
  logic        mem_wait;
  logic        stall;
  logic        wb_valid;
  logic [2:0]  wb_waddr;
  logic [15:0] wb_wdata;

  // Program table and the write-backs the model expects from it
  logic [15:0] prog [$];
  int          n_directed;
  logic [2:0]  exp_addr [$];
  logic [15:0] exp_data [$];
  logic [15:0] model_regs [8];

  logic [31:0] lfsr;
  logic        wait_en;
  int          mismatch_errors;
  int          other_errors;
  int          loaduse_stalls;

  mini_pipe_top i_mini_pipe_top (
    .clk_i         (clk),
    .reset_i       (reset),
    .instr_valid_i (instr_valid),
    .instr_i       (instr),
    .mem_wait_i    (mem_wait),
    .stall_o       (stall),
    .wb_valid_o    (wb_valid),
    .wb_waddr_o    (wb_waddr),
    .wb_wdata_o    (wb_wdata)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [15:0] encode(input logic [2:0] op, input logic [2:0] rd,
                                         input logic [2:0] rs1, input logic [2:0] rs2,
                                         input logic [3:0] imm);
    return {op, rd, rs1, rs2, imm};
  endfunction

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit, first bit ends up as the MSB of the n taken
  task automatic take_bits(input int n, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[14:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic build_program();
    logic [15:0] w;
    // Seed registers, then independent ALU ops
    prog.push_back(encode(ADDI, 3'd1, 3'd0, 3'd0, 4'd7));
    prog.push_back(encode(ADDI, 3'd2, 3'd0, 3'd0, 4'd3));
    prog.push_back(encode(ADDI, 3'd3, 3'd0, 3'd0, 4'd12));
    prog.push_back(encode(ADDI, 3'd4, 3'd0, 3'd0, 4'd9));
    prog.push_back(encode(NOP,  3'd0, 3'd0, 3'd0, 4'd0));
    prog.push_back(encode(ADD,  3'd5, 3'd1, 3'd2, 4'd0));
    prog.push_back(encode(SUB,  3'd6, 3'd3, 3'd4, 4'd0));
    prog.push_back(encode(XOR,  3'd7, 3'd1, 3'd3, 4'd0));
    // Back to back on a, on b, on both
    prog.push_back(encode(ADDI, 3'd1, 3'd2, 3'd0, 4'd1));
    prog.push_back(encode(ADD,  3'd2, 3'd1, 3'd3, 4'd0));
    prog.push_back(encode(SUB,  3'd3, 3'd4, 3'd2, 4'd0));
    prog.push_back(encode(XOR,  3'd4, 3'd3, 3'd3, 4'd0));
    // r5 sits in EX and WB at once, the younger value must win
    prog.push_back(encode(ADDI, 3'd5, 3'd0, 3'd0, 4'd1));
    prog.push_back(encode(ADDI, 3'd5, 3'd5, 3'd0, 4'd2));
    prog.push_back(encode(ADD,  3'd6, 3'd5, 3'd5, 4'd0));
    // Distance two through WB, distance three through the register file
    prog.push_back(encode(ADDI, 3'd1, 3'd0, 3'd0, 4'd11));
    prog.push_back(encode(NOP,  3'd0, 3'd0, 3'd0, 4'd0));
    prog.push_back(encode(ADD,  3'd2, 3'd1, 3'd1, 4'd0));
    prog.push_back(encode(ADDI, 3'd3, 3'd0, 3'd0, 4'd6));
    prog.push_back(encode(NOP,  3'd0, 3'd0, 3'd0, 4'd0));
    prog.push_back(encode(NOP,  3'd0, 3'd0, 3'd0, 4'd0));
    prog.push_back(encode(SUB,  3'd4, 3'd3, 3'd2, 4'd0));
    // Load then immediate use, on a and on b
    prog.push_back(encode(LD,   3'd5, 3'd1, 3'd0, 4'd3));
    prog.push_back(encode(ADD,  3'd6, 3'd5, 3'd2, 4'd0));
    prog.push_back(encode(LD,   3'd7, 3'd6, 3'd0, 4'd0));
    prog.push_back(encode(SUB,  3'd1, 3'd4, 3'd7, 4'd0));
    // Writes to r0 and reads of it right after
    prog.push_back(encode(ADDI, 3'd0, 3'd1, 3'd0, 4'd5));
    prog.push_back(encode(ADD,  3'd3, 3'd0, 3'd1, 4'd0));
    prog.push_back(encode(ADD,  3'd0, 3'd1, 3'd2, 4'd0));
    prog.push_back(encode(SUB,  3'd4, 3'd0, 3'd0, 4'd0));
    prog.push_back(encode(LD,   3'd0, 3'd2, 3'd0, 4'd1));
    prog.push_back(encode(XOR,  3'd5, 3'd0, 3'd3, 4'd0));
    n_directed = prog.size();
    // Mixed random tail, codes 6 and 7 included
    for (int i = 0; i < N_RANDOM; i++) begin
      take_bits(16, w);
      prog.push_back(w);
    end
  endtask

  // In-order execution of the whole table
  task automatic run_model();
    logic [2:0]  op;
    logic [2:0]  rd;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] imm;
    logic [15:0] res;
    logic        writes;
    foreach (model_regs[i]) begin
      model_regs[i] = '0;
    end
    foreach (prog[k]) begin
      op     = prog[k][15:13];
      rd     = prog[k][12:10];
      a      = model_regs[prog[k][9:7]];
      b      = model_regs[prog[k][6:4]];
      imm    = {12'h000, prog[k][3:0]};
      writes = 1'b1;
      case (op)
        ADD:     res = a + b;
        SUB:     res = a - b;
        XOR:     res = a ^ b;
        ADDI:    res = a + imm;
        LD:      res = (a + imm) ^ LOAD_XOR;
        default: begin
          res    = '0;
          writes = 1'b0;
        end
      endcase
      // r0 stays zero and never retires
      if (writes && (rd != 3'd0)) begin
        model_regs[rd] = res;
        exp_addr.push_back(rd);
        exp_data.push_back(res);
      end
    end
  endtask

  task automatic check_retire();
    logic [2:0]  ea;
    logic [15:0] ed;
    assert (wb_waddr != 3'd0) else begin
      other_errors++;
      $display("write-back to register 0 was retired");
    end
    assert (exp_addr.size() != 0) else begin
      other_errors++;
      $display("write-back to r%0d arrived with no result pending", wb_waddr);
    end
    if (exp_addr.size() != 0) begin
      ea = exp_addr.pop_front();
      ed = exp_data.pop_front();
      assert (wb_waddr == ea) else begin
        mismatch_errors++;
        $display("mismatch wb_waddr_o: got 0x%h, expected 0x%h", wb_waddr, ea);
      end
      assert (wb_wdata == ed) else begin
        mismatch_errors++;
        $display("mismatch wb_wdata_o: got 0x%h, expected 0x%h", wb_wdata, ed);
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Wait states and monitor
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin : wait_gen
    logic [15:0] bits;
    if (wait_en) begin
      take_bits(1, bits);
      mem_wait <= bits[0];
    end else begin
      mem_wait <= 1'b0;
    end
  end

  // Every retire pulse is checked against the model
  always @(negedge clk) begin
    if (!reset) begin
      if (wb_valid) begin
        check_retire();
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    int guard;
    reset           = 1'b1;
    instr_valid     = 1'b0;
    instr           = '0;
    mem_wait        = 1'b0;
    wait_en         = 1'b0;
    lfsr            = 32'h0196_b41f;
    mismatch_errors = 0;
    other_errors    = 0;
    loaduse_stalls  = 0;
    build_program();
    run_model();

    repeat (4) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    assert (!stall && !wb_valid) else begin
      other_errors++;
      $display("stall_o or wb_valid_o high in the first cycle after reset");
    end

    for (int k = 0; k < prog.size(); k++) begin
      @(posedge clk);
      instr_valid <= 1'b1;
      instr       <= prog[k];
      wait_en     <= (k >= n_directed);
      // Word is taken on the next edge with stall_o low
      guard = 0;
      do begin
        @(negedge clk);
        guard++;
      end while (stall && (guard < STALL_LIMIT));
      assert (!stall) else begin
        other_errors++;
        $display("timeout: instruction %0d held by stall_o for %0d cycles", k, guard);
      end
      // The directed part runs without wait states
      // A stall there can only come from a load and its user
      if ((k < n_directed) && (guard > 1)) begin
        loaduse_stalls++;
      end
    end
    @(posedge clk);
    instr_valid <= 1'b0;
    wait_en     <= 1'b0;

    // Drain the pipe
    guard = 0;
    while ((exp_addr.size() != 0) && (guard < DRAIN_LIMIT)) begin
      @(negedge clk);
      guard++;
    end
    assert (exp_addr.size() == 0) else begin
      other_errors++;
      $display("timeout: %0d expected write-backs never retired", exp_addr.size());
    end
    // A few idle cycles to catch stray pulses
    repeat (8) @(negedge clk);
    assert (loaduse_stalls > 0) else begin
      other_errors++;
      $display("load followed by a user never raised stall_o");
    end

    $display("errors: %0d mismatch, %0d other", mismatch_errors, other_errors);
    if ((mismatch_errors + other_errors) == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== mini_pipe.f ====
+incdir+.
mini_pipe_pkg.sv
mini_pipe_decoder.sv
mini_pipe_regfile.sv
mini_pipe_bypass.sv
mini_pipe_ex.sv
mini_pipe_wb.sv
mini_pipe_top.sv
mini_pipe_tb.sv

// ==== Bender.yml ====
package:
  name: mini_pipe

sources:
  - include_dirs:
      - .
    files:
      - mini_pipe_pkg.sv
      - mini_pipe_decoder.sv
      - mini_pipe_regfile.sv
      - mini_pipe_bypass.sv
      - mini_pipe_ex.sv
      - mini_pipe_wb.sv
      - mini_pipe_top.sv
  - target: simulation
    files:
      - mini_pipe_tb.sv
